// File: Bender.yml
package:
  name: line_cache

dependencies: {}

sources:
  # package first, then the RTL bottom up
  - files:
      - src/line_cache_pkg.sv
      - src/cache_ram.sv
      - src/word_lane_select.sv
      - src/cache_controller.sv
      - src/line_cache_top.sv
  # bound assertions and the testbench
  - target: simulation
    files:
      - sim/line_cache_sva.sv
      - sim/line_cache_tb.sv

// File: build.f
src/line_cache_pkg.sv
src/cache_ram.sv
src/word_lane_select.sv
src/cache_controller.sv
src/line_cache_top.sv
sim/line_cache_sva.sv
sim/line_cache_tb.sv

// File: sim/line_cache_sva.sv
// ------------------------------
// master and slave handshake assertions on line_cache_top
// ------------------------------

`timescale 1ns/10ps

module line_cache_sva import line_cache_pkg::*; #(
	parameter int  ADDR_WIDTH = DEF_ADDR_WIDTH,
	parameter int  WORD_WIDTH = DEF_WORD_WIDTH,
	parameter int  LINE_SIZE  = DEF_LINE_SIZE,
	localparam int LINE_WIDTH = WORD_WIDTH << LINE_SIZE
) (
	input logic                            clk,
	input logic                            reset,
	input logic                            s_ready,
	input logic                            m_en,
	input logic                            m_we,
	input logic [ADDR_WIDTH-LINE_SIZE-1:0] m_addr,
	input logic [LINE_WIDTH/8-1:0]         m_bls,
	input logic [LINE_WIDTH-1:0]           m_wdata,
	input logic                            m_ready,
	input ctrl_state_t                     state
);

	int fail_count = 0;

	// pending beat holds every master output
	a_beat_stable: assert property (@(posedge clk) disable iff (reset)
		m_en && !m_ready |=> m_en && $stable(m_we) && $stable(m_addr)
			&& $stable(m_bls) && $stable(m_wdata))
	else begin
		$error("master outputs changed while a beat was pending");
		fail_count++;
	end

	a_reset_idle: assert property (@(posedge clk) reset |=> !m_en)
	else begin
		$error("m_en high after reset");
		fail_count++;
	end

	a_refill_stall: assert property (@(posedge clk) disable iff (reset)
		!(state == ST_REFILL && s_ready))
	else begin
		$error("s_ready high during refill");
		fail_count++;
	end

endmodule

bind line_cache_top line_cache_sva #(
	.ADDR_WIDTH (ADDR_WIDTH),
	.WORD_WIDTH (WORD_WIDTH),
	.LINE_SIZE  (LINE_SIZE)
) u_sva (
	.clk     (clk),
	.reset   (reset),
	.s_ready (s_ready),
	.m_en    (m_en),
	.m_we    (m_we),
	.m_addr  (m_addr),
	.m_bls   (m_bls),
	.m_wdata (m_wdata),
	.m_ready (m_ready),
	.state   (u_ctrl.state)
);

// File: sim/line_cache_tb.sv
// ------------------------------
// directed testbench with a line memory model
// test addresses must stay within the first 256 lines of the model
// ------------------------------

`timescale 1ns/10ps

module line_cache_tb import line_cache_pkg::*; ();

	localparam int ADDR_WIDTH  = DEF_ADDR_WIDTH;
	localparam int WORD_WIDTH  = DEF_WORD_WIDTH;
	localparam int LINE_SIZE   = DEF_LINE_SIZE;
	localparam int INDEX_WIDTH = DEF_INDEX_WIDTH;
	localparam int LINE_WORDS  = 1 << LINE_SIZE;
	localparam int LINE_WIDTH  = WORD_WIDTH << LINE_SIZE;
	localparam int WORD_BYTES  = WORD_WIDTH / 8;
	localparam int LINE_BYTES  = LINE_WIDTH / 8;
	localparam int MODEL_LINES = 256;
	localparam int TIMEOUT     = 200;

	typedef logic [ADDR_WIDTH-1:0]           addr_t;
	typedef logic [ADDR_WIDTH-LINE_SIZE-1:0] maddr_t;
	typedef logic [WORD_WIDTH-1:0]           word_t;
	typedef logic [LINE_WIDTH-1:0]           line_t;
	typedef logic [WORD_BYTES-1:0]           wbls_t;
	typedef logic [LINE_BYTES-1:0]           lbls_t;

	logic    clk;
	logic    reset;
	endian_t endian;
	logic    s_en;
	logic    s_we;
	addr_t   s_addr;
	wbls_t   s_bls;
	word_t   s_wdata;
	word_t   s_rdata;
	logic    s_ready;
	logic    m_en;
	logic    m_we;
	maddr_t  m_addr;
	lbls_t   m_bls;
	line_t   m_wdata;
	line_t   m_rdata;
	logic    m_ready;

	line_t       mem_model [0:MODEL_LINES-1];
	maddr_t      wr_addr_q[$];
	lbls_t       wr_bls_q[$];
	line_t       wr_data_q[$];
	int          master_reads = 0;
	int          checks = 0;
	int          errors = 0;
	bit          hung = 1'b0;
	logic [31:0] rng_state = 32'hd34b_a45b;
	logic [31:0] wait_state;
	int          wait_left;
	bit          beat_busy;

	line_cache_top u_dut (
		.clk     (clk),
		.reset   (reset),
		.endian  (endian),
		.s_en    (s_en),
		.s_we    (s_we),
		.s_addr  (s_addr),
		.s_bls   (s_bls),
		.s_wdata (s_wdata),
		.s_rdata (s_rdata),
		.s_ready (s_ready),
		.m_en    (m_en),
		.m_we    (m_we),
		.m_addr  (m_addr),
		.m_bls   (m_bls),
		.m_wdata (m_wdata),
		.m_rdata (m_rdata),
		.m_ready (m_ready)
	);

	always #10 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic addr_t word_addr(input int tag, input int index, input int offset);
		addr_t a;
		a = addr_t'(tag);
		a = (a << INDEX_WIDTH) | addr_t'(index);
		a = (a << LINE_SIZE) | addr_t'(offset);
		return a;
	endfunction

	// big endian mirrors the word offset
	function automatic int lane_of(input endian_t e, input int offset);
		return (e == ENDIAN_BIG) ? LINE_WORDS - 1 - offset : offset;
	endfunction

	function automatic word_t model_word(input addr_t addr);
		line_t l;
		int    off;
		l = mem_model[addr >> LINE_SIZE];
		off = addr[LINE_SIZE-1:0];
		return l[lane_of(endian, off)*WORD_WIDTH +: WORD_WIDTH];
	endfunction

	function automatic word_t merge_word(input word_t old, input word_t wdata, input wbls_t bls);
		word_t w;
		w = old;
		for (int b = 0; b < WORD_BYTES; b++) begin
			if (bls[b]) begin
				w[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return w;
	endfunction

	// ------------------------------
	// memory model
	// ------------------------------

	task automatic serve_beat();
		if (m_addr >= MODEL_LINES) begin
			errors++;
			$display("ERROR @%0t: master address %h is outside the memory model", $time, m_addr);
		end else if (m_we) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (m_bls[b]) begin
					mem_model[m_addr][b*8 +: 8] = m_wdata[b*8 +: 8];
				end
			end
			wr_addr_q.push_back(m_addr);
			wr_bls_q.push_back(m_bls);
			wr_data_q.push_back(m_wdata);
		end else begin
			m_rdata = mem_model[m_addr];
			master_reads++;
		end
	endtask

	// answers after 0 to 3 wait cycles with a one-cycle m_ready pulse
	always @(negedge clk) begin
		if (reset) begin
			m_ready = 1'b0;
			beat_busy = 1'b0;
		end else if (m_ready) begin
			m_ready = 1'b0;
		end else if (m_en) begin
			if (!beat_busy) begin
				beat_busy = 1'b1;
				wait_state = xorshift32(wait_state);
				wait_left = wait_state % 4;
			end
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				serve_beat();
				beat_busy = 1'b0;
				m_ready = 1'b1;
			end
		end
	end

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic check_word(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR @%0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_line_write(input string what, input maddr_t got_addr,
			input lbls_t got_bls, input line_t got_data, input maddr_t exp_addr,
			input lbls_t exp_bls, input line_t exp_data);
		checks++;
		if (got_addr !== exp_addr || got_bls !== exp_bls || got_data !== exp_data) begin
			errors++;
			$display("ERROR @%0t: %s addr %h bls %h data %h, expected %h %h %h", $time,
				what, got_addr, got_bls, got_data, exp_addr, exp_bls, exp_data);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// bus access
	// ------------------------------

	task automatic report_hang(input string what);
		hung = 1'b1;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic set_endian(input endian_t e);
		@(negedge clk);
		endian = e;
	endtask

	task automatic bus_access(input logic we, input addr_t addr, input wbls_t bls,
			input word_t wdata, output word_t rdata);
		int cycles;
		rdata = 'x;
		if (hung) begin
			return;
		end
		@(negedge clk);
		s_en = 1'b1;
		s_we = we;
		s_addr = addr;
		s_bls = bls;
		s_wdata = wdata;
		cycles = 0;
		while (!s_ready && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!s_ready) begin
			s_en = 1'b0;
			report_hang("the cache to accept a request");
			return;
		end
		// accepted on the rising edge in between
		@(negedge clk);
		s_en = 1'b0;
		cycles = 0;
		while (!s_ready && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!s_ready) begin
			report_hang("the cache to finish a request");
			return;
		end
		rdata = s_rdata;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------

	task automatic end_test(input string name, input int start_errors);
		$display("test %s finished with %0d errors", name, errors - start_errors);
	endtask

	task automatic test_read_miss_hit(input string name, input int tag, input int index);
		int    start_errors;
		int    reads0;
		addr_t a;
		word_t got;
		start_errors = errors;
		reads0 = master_reads;
		a = word_addr(tag, index, 1);
		bus_access(1'b0, a, '0, '0, got);
		check_word("miss read", got, model_word(a));
		check_count("master reads after miss", master_reads, reads0 + 1);
		for (int off = 0; off < LINE_WORDS; off++) begin
			a = word_addr(tag, index, off);
			bus_access(1'b0, a, '0, '0, got);
			check_word("hit read", got, model_word(a));
		end
		check_count("master reads after hits", master_reads, reads0 + 1);
		end_test(name, start_errors);
	endtask

	// first line of the pair is cached by the read test and the second is not
	task automatic test_write_through(input string name, input int tag, input int index);
		int          start_errors;
		int          reads0;
		int          off;
		addr_t       a;
		wbls_t       bls;
		word_t       wdata;
		word_t       got;
		logic [31:0] r;
		start_errors = errors;
		for (int i = 0; i < 2 * LINE_WORDS; i++) begin
			off = i % LINE_WORDS;
			a = word_addr(tag, index + i / LINE_WORDS, off);
			r = next_random();
			bls = r[WORD_BYTES-1:0];
			if (bls == '0) begin
				bls = '1;
			end
			wdata = next_random();
			reads0 = master_reads;
			wr_addr_q.delete();
			wr_bls_q.delete();
			wr_data_q.delete();
			bus_access(1'b1, a, bls, wdata, got);
			check_count("master writes per write", wr_addr_q.size(), 1);
			check_count("master reads during write", master_reads, reads0);
			if (wr_addr_q.size() > 0) begin
				check_line_write("write beat", wr_addr_q.pop_front(), wr_bls_q.pop_front(),
					wr_data_q.pop_front(), maddr_t'(a >> LINE_SIZE),
					lbls_t'(bls) << (lane_of(endian, off) * WORD_BYTES),
					{LINE_WORDS{wdata}});
			end
		end
		end_test(name, start_errors);
	endtask

	task automatic test_write_hit_merge(input string name, input int tag, input int index);
		int    start_errors;
		int    reads0;
		addr_t a;
		wbls_t bls;
		word_t old;
		word_t wdata;
		word_t got;
		start_errors = errors;
		a = word_addr(tag, index, 2);
		old = model_word(a);
		bus_access(1'b0, a, '0, '0, got);
		check_word("read before merge", got, old);
		reads0 = master_reads;
		// every other byte
		for (int b = 0; b < WORD_BYTES; b++) begin
			bls[b] = (b % 2 == 0);
		end
		wdata = next_random();
		bus_access(1'b1, a, bls, wdata, got);
		bus_access(1'b0, a, '0, '0, got);
		check_word("merged word", got, merge_word(old, wdata, bls));
		check_count("master reads after merge", master_reads, reads0);
		end_test(name, start_errors);
	endtask

	task automatic test_write_miss(input string name, input int tag, input int index);
		int    start_errors;
		int    reads0;
		addr_t a;
		wbls_t bls;
		word_t old;
		word_t wdata;
		word_t got;
		start_errors = errors;
		a = word_addr(tag, index, LINE_WORDS - 1);
		old = model_word(a);
		for (int b = 0; b < WORD_BYTES; b++) begin
			bls[b] = (b >= WORD_BYTES / 2);
		end
		wdata = next_random();
		reads0 = master_reads;
		bus_access(1'b1, a, bls, wdata, got);
		check_count("master reads after write miss", master_reads, reads0);
		bus_access(1'b0, a, '0, '0, got);
		check_count("master reads after read", master_reads, reads0 + 1);
		check_word("read after write miss", got, merge_word(old, wdata, bls));
		end_test(name, start_errors);
	endtask

	task automatic test_conflict(input string name, input int index);
		int    start_errors;
		int    reads0;
		int    tags [3];
		addr_t a;
		word_t got;
		start_errors = errors;
		tags = '{1, 2, 1};
		reads0 = master_reads;
		foreach (tags[i]) begin
			a = word_addr(tags[i], index, i);
			bus_access(1'b0, a, '0, '0, got);
			check_word("conflicting read", got, model_word(a));
		end
		check_count("master reads for conflicts", master_reads, reads0 + 3);
		end_test(name, start_errors);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		int    cycles;
		int    sva_fails;
		line_t l;
		clk = 1'b0;
		reset = 1'b1;
		endian = ENDIAN_LITTLE;
		s_en = 1'b0;
		s_we = 1'b0;
		s_addr = '0;
		s_bls = '0;
		s_wdata = '0;
		m_rdata = '0;
		m_ready = 1'b0;
		for (int i = 0; i < MODEL_LINES; i++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				l[w*WORD_WIDTH +: WORD_WIDTH] = next_random();
			end
			mem_model[i] = l;
		end
		wait_state = rng_state;

		repeat (3) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!s_ready && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!s_ready) begin
			report_hang("s_ready after the reset sweep");
		end

		test_read_miss_hit("read miss then hit", 0, 1);
		test_write_through("write-through", 0, 1);
		test_write_hit_merge("write hit merge", 0, 4);
		test_write_miss("write miss no allocate", 0, 5);
		test_conflict("conflict eviction", 20);
		set_endian(ENDIAN_BIG);
		test_read_miss_hit("big endian read", 2, 8);
		test_write_through("big endian write", 2, 8);

		sva_fails = u_dut.u_sva.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0 && !hung) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: src/cache_controller.sv
// ------------------------------
// direct-mapped write-through control, no write allocate
// tag store is swept invalid after reset, s_ready low meanwhile
// ------------------------------

`timescale 1ns/10ps

module cache_controller import line_cache_pkg::*; #(
	parameter int   ADDR_WIDTH  = DEF_ADDR_WIDTH,
	parameter int   WORD_WIDTH  = DEF_WORD_WIDTH,
	parameter int   LINE_SIZE   = DEF_LINE_SIZE,
	parameter int   INDEX_WIDTH = DEF_INDEX_WIDTH,
	localparam int  TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - LINE_SIZE,
	localparam int  LINE_WIDTH  = WORD_WIDTH << LINE_SIZE,
	localparam int  LINE_WORDS  = 1 << LINE_SIZE,
	localparam int  WORD_BYTES  = WORD_WIDTH / 8,
	localparam int  LINE_BYTES  = LINE_WIDTH / 8,
	parameter type  tag_entry_t = logic [TAG_WIDTH:0],
	parameter type  line_t      = logic [LINE_WIDTH-1:0]
) (
	input  logic                           clk,
	input  logic                           reset,
	input  endian_t                        endian,

	// slave bus
	input  logic                           s_en,
	input  logic                           s_we,
	input  logic [ADDR_WIDTH-1:0]          s_addr,
	input  logic [WORD_BYTES-1:0]          s_bls,
	input  logic [WORD_WIDTH-1:0]          s_wdata,
	output logic [WORD_WIDTH-1:0]          s_rdata,
	output logic                           s_ready,

	// master bus
	output logic                           m_en,
	output logic                           m_we,
	output logic [ADDR_WIDTH-LINE_SIZE-1:0] m_addr,
	output logic [LINE_BYTES-1:0]          m_bls,
	output line_t                          m_wdata,
	input  line_t                          m_rdata,
	input  logic                           m_ready,

	// tag store
	output logic                           tag_en,
	output logic                           tag_we,
	output logic [INDEX_WIDTH-1:0]         tag_addr,
	output tag_entry_t                     tag_wdata,
	input  tag_entry_t                     tag_rdata,

	// data store
	output logic                           data_en,
	output logic                           data_we,
	output logic [INDEX_WIDTH-1:0]         data_addr,
	output line_t                          data_wdata,
	input  line_t                          data_rdata
);

	ctrl_state_t state;

	logic                   sweep_busy;
	logic [INDEX_WIDTH-1:0] sweep_idx;

	// accepted request
	logic                   req_we;
	logic [LINE_SIZE-1:0]   req_offset;
	logic [INDEX_WIDTH-1:0] req_index;
	logic [TAG_WIDTH-1:0]   req_tag;
	logic [WORD_BYTES-1:0]  req_bls;
	logic [WORD_WIDTH-1:0]  req_wdata;

	line_t                  refill_line;
	line_t                  sel_line;

	logic                   tag_valid;
	logic [TAG_WIDTH-1:0]   tag_value;
	logic                   hit;
	logic                   accept;
	logic                   issue;
	logic                   write_hit;
	logic                   refill_done;
	logic                   store_write;
	logic [INDEX_WIDTH-1:0] store_idx;
	logic [LINE_BYTES-1:0]  lane_bls;
	line_t                  merged;

	// ------------------------------
	// hit test and decisions
	// ------------------------------

	assign {tag_valid, tag_value} = tag_rdata;

	assign hit         = tag_valid && (tag_value == req_tag);
	assign accept      = s_en && s_ready;
	assign issue       = (state == ST_LOOKUP) && (req_we || !hit);
	assign write_hit   = (state == ST_LOOKUP) && req_we && hit;
	assign refill_done = (state == ST_REFILL) && m_ready;

	always_comb begin
		case (state)
			ST_IDLE:   s_ready = !sweep_busy;
			ST_LOOKUP: s_ready = !req_we && hit;
			default:   s_ready = 1'b0;
		endcase
	end

	// lookup reads the store, the cycle after a refill reads the register
	assign sel_line = (state == ST_LOOKUP) ? data_rdata : refill_line;

	word_lane_select #(
		.WORD_WIDTH (WORD_WIDTH),
		.LINE_SIZE  (LINE_SIZE)
	) u_lanes (
		.endian   (endian),
		.offset   (req_offset),
		.line     (sel_line),
		.bls      (req_bls),
		.wdata    (req_wdata),
		.rword    (s_rdata),
		.line_bls (lane_bls),
		.merged   (merged)
	);

	// ------------------------------
	// store control
	// ------------------------------

	assign store_write = refill_done || write_hit;

	always_comb begin
		if (sweep_busy) begin
			store_idx = sweep_idx;
		end else if (store_write) begin
			store_idx = req_index;
		end else begin
			store_idx = s_addr[LINE_SIZE +: INDEX_WIDTH];
		end
	end

	assign tag_en    = sweep_busy || refill_done || accept;
	assign tag_we    = sweep_busy || refill_done;
	assign tag_addr  = store_idx;
	assign tag_wdata = sweep_busy ? tag_entry_t'('0) : tag_entry_t'({1'b1, req_tag});

	// write hit only touches the data store
	assign data_en    = store_write || accept;
	assign data_we    = store_write;
	assign data_addr  = store_idx;
	assign data_wdata = refill_done ? m_rdata : merged;

	// ------------------------------
	// control state
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_IDLE;
			m_en       <= 1'b0;
			sweep_busy <= 1'b1;
			sweep_idx  <= '0;
		end else begin
			if (sweep_busy) begin
				sweep_idx <= sweep_idx + 1'b1;
				if (&sweep_idx) begin
					sweep_busy <= 1'b0;
				end
			end

			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (issue) begin
						state <= req_we ? ST_WRITE : ST_REFILL;
						m_en  <= 1'b1;
					end else if (!accept) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					// refill or write-through beat outstanding
					if (m_ready) begin
						state <= ST_IDLE;
						m_en  <= 1'b0;
					end
				end
			endcase
		end
	end

	// ------------------------------
	// request and beat payload
	// ------------------------------

	always_ff @(posedge clk) begin
		if (accept) begin
			req_we     <= s_we;
			req_offset <= s_addr[0 +: LINE_SIZE];
			req_index  <= s_addr[LINE_SIZE +: INDEX_WIDTH];
			req_tag    <= s_addr[LINE_SIZE + INDEX_WIDTH +: TAG_WIDTH];
			req_bls    <= s_bls;
			req_wdata  <= s_wdata;
		end

		// master outputs frozen while the beat is pending
		if (issue) begin
			m_we    <= req_we;
			m_addr  <= {req_tag, req_index};
			m_bls   <= req_we ? lane_bls : '1;
			m_wdata <= {LINE_WORDS{req_wdata}};
		end

		if (refill_done) begin
			refill_line <= m_rdata;
		end
	end

endmodule

// File: src/cache_ram.sv
// ------------------------------
// single-port synchronous RAM, one entry per index
// rdata holds its value except after an enabled read
// ------------------------------

`timescale 1ns/10ps

module cache_ram #(
	parameter type entry_t     = logic [31:0],
	parameter int  DEPTH_WIDTH = 6
) (
	input  logic                   clk,
	input  logic                   en,
	input  logic                   we,
	input  logic [DEPTH_WIDTH-1:0] addr,
	input  entry_t                 wdata,
	output entry_t                 rdata
);

	entry_t mem [0:(1 << DEPTH_WIDTH)-1];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// File: src/line_cache_pkg.sv
// ------------------------------
// shared types and default geometry for the line cache
// widths are in bits unless noted; sizes are log2
// ------------------------------

package line_cache_pkg;

	// ------------------------------
	// controller states
	// ------------------------------

	// reset sweep runs in ST_IDLE with its own busy flag
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_LOOKUP = 2'd1,
		ST_REFILL = 2'd2,
		ST_WRITE  = 2'd3
	} ctrl_state_t;

	// ------------------------------
	// lane order within a line
	// ------------------------------

	// big endian puts offset k on lane LINE_WORDS-1-k
	typedef enum logic {
		ENDIAN_LITTLE = 1'b0,
		ENDIAN_BIG    = 1'b1
	} endian_t;

	// ------------------------------
	// default geometry
	// ------------------------------

	// word address width
	localparam int DEF_ADDR_WIDTH = 24;

	// word width, a multiple of 8
	localparam int DEF_WORD_WIDTH = 32;

	// words per line, log2, at least 1
	localparam int DEF_LINE_SIZE = 2;

	// number of lines, log2
	localparam int DEF_INDEX_WIDTH = 6;

endpackage

// File: src/line_cache_top.sv
// ------------------------------
// line cache top, tag and data stores beside the controller
// endian must stay stable while requests are in flight
// ------------------------------

`timescale 1ns/10ps

module line_cache_top import line_cache_pkg::*; #(
	parameter int   ADDR_WIDTH  = DEF_ADDR_WIDTH,
	parameter int   WORD_WIDTH  = DEF_WORD_WIDTH,
	parameter int   LINE_SIZE   = DEF_LINE_SIZE,
	parameter int   INDEX_WIDTH = DEF_INDEX_WIDTH,
	localparam int  TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - LINE_SIZE,
	localparam int  LINE_WIDTH  = WORD_WIDTH << LINE_SIZE,
	localparam int  WORD_BYTES  = WORD_WIDTH / 8,
	localparam int  LINE_BYTES  = LINE_WIDTH / 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  endian_t                         endian,

	// slave bus
	input  logic                            s_en,
	input  logic                            s_we,
	input  logic [ADDR_WIDTH-1:0]           s_addr,
	input  logic [WORD_BYTES-1:0]           s_bls,
	input  logic [WORD_WIDTH-1:0]           s_wdata,
	output logic [WORD_WIDTH-1:0]           s_rdata,
	output logic                            s_ready,

	// master bus
	output logic                            m_en,
	output logic                            m_we,
	output logic [ADDR_WIDTH-LINE_SIZE-1:0] m_addr,
	output logic [LINE_BYTES-1:0]           m_bls,
	output logic [LINE_WIDTH-1:0]           m_wdata,
	input  logic [LINE_WIDTH-1:0]           m_rdata,
	input  logic                            m_ready
);

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	typedef logic [LINE_WIDTH-1:0] line_t;

	logic                   tag_en;
	logic                   tag_we;
	logic [INDEX_WIDTH-1:0] tag_addr;
	tag_entry_t             tag_wdata;
	tag_entry_t             tag_rdata;

	logic                   data_en;
	logic                   data_we;
	logic [INDEX_WIDTH-1:0] data_addr;
	line_t                  data_wdata;
	line_t                  data_rdata;

	cache_ram #(
		.entry_t     (tag_entry_t),
		.DEPTH_WIDTH (INDEX_WIDTH)
	) u_tag_store (
		.clk   (clk),
		.en    (tag_en),
		.we    (tag_we),
		.addr  (tag_addr),
		.wdata (tag_wdata),
		.rdata (tag_rdata)
	);

	cache_ram #(
		.entry_t     (line_t),
		.DEPTH_WIDTH (INDEX_WIDTH)
	) u_data_store (
		.clk   (clk),
		.en    (data_en),
		.we    (data_we),
		.addr  (data_addr),
		.wdata (data_wdata),
		.rdata (data_rdata)
	);

	cache_controller #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.WORD_WIDTH  (WORD_WIDTH),
		.LINE_SIZE   (LINE_SIZE),
		.INDEX_WIDTH (INDEX_WIDTH),
		.tag_entry_t (tag_entry_t),
		.line_t      (line_t)
	) u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.endian     (endian),
		.s_en       (s_en),
		.s_we       (s_we),
		.s_addr     (s_addr),
		.s_bls      (s_bls),
		.s_wdata    (s_wdata),
		.s_rdata    (s_rdata),
		.s_ready    (s_ready),
		.m_en       (m_en),
		.m_we       (m_we),
		.m_addr     (m_addr),
		.m_bls      (m_bls),
		.m_wdata    (m_wdata),
		.m_rdata    (m_rdata),
		.m_ready    (m_ready),
		.tag_en     (tag_en),
		.tag_we     (tag_we),
		.tag_addr   (tag_addr),
		.tag_wdata  (tag_wdata),
		.tag_rdata  (tag_rdata),
		.data_en    (data_en),
		.data_we    (data_we),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_rdata (data_rdata)
	);

endmodule

// File: src/word_lane_select.sv
// ------------------------------
// word pick, lane enables and byte merge for one line
// needs LINE_SIZE >= 1 and WORD_WIDTH a multiple of 8
// ------------------------------

`timescale 1ns/10ps

module word_lane_select import line_cache_pkg::*; #(
	parameter int   WORD_WIDTH = DEF_WORD_WIDTH,
	parameter int   LINE_SIZE  = DEF_LINE_SIZE,
	localparam int  LINE_WORDS = 1 << LINE_SIZE,
	localparam int  LINE_WIDTH = WORD_WIDTH << LINE_SIZE,
	localparam int  WORD_BYTES = WORD_WIDTH / 8,
	localparam int  LINE_BYTES = LINE_WIDTH / 8
) (
	input  endian_t                endian,
	input  logic [LINE_SIZE-1:0]   offset,
	input  logic [LINE_WIDTH-1:0]  line,
	input  logic [WORD_BYTES-1:0]  bls,
	input  logic [WORD_WIDTH-1:0]  wdata,
	output logic [WORD_WIDTH-1:0]  rword,
	output logic [LINE_BYTES-1:0]  line_bls,
	output logic [LINE_WIDTH-1:0]  merged
);

	logic [LINE_SIZE-1:0] lane;

	// inverting the offset gives LINE_WORDS-1-offset
	assign lane = (endian == ENDIAN_BIG) ? ~offset : offset;

	assign rword = line[lane*WORD_WIDTH +: WORD_WIDTH];

	// ------------------------------
	// lane enables
	// ------------------------------

	for (genvar w = 0; w < LINE_WORDS; w++) begin : g_lane
		assign line_bls[w*WORD_BYTES +: WORD_BYTES] = (lane == w) ? bls : '0;
	end

	// ------------------------------
	// byte merge
	// ------------------------------

	// write word is replicated, so byte b takes byte b mod WORD_BYTES of it
	for (genvar b = 0; b < LINE_BYTES; b++) begin : g_byte
		assign merged[b*8 +: 8] = line_bls[b] ? wdata[(b % WORD_BYTES)*8 +: 8]
		                                      : line[b*8 +: 8];
	end

endmodule
